// File: load_queue.f
+incdir+rtl
rtl/lq_pkg.sv
rtl/rr_arbiter.sv
rtl/lq_alloc.sv
rtl/store_forward.sv
rtl/lq_entries.sv
rtl/load_queue.sv
verif/lq_clock_gen.sv
verif/tb_load_queue.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the load queue testbench, exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f load_queue.f --top-module tb_load_queue \
    -Mdir obj_dir -o tb_load_queue &&
./obj_dir/tb_load_queue ||
{ echo "load queue simulation failed"; exit 1; }

// File: verif/tb_load_queue.sv
`include "lq_config.svh"

module tb_load_queue;
    timeunit 1ns;
    timeprecision 1ps;
    import lq_pkg::*;

    localparam int unsigned SEED = 32'h483a;
    localparam int TIMEOUT = 200;
    localparam int ROBS = 2 ** `LQ_ROB_BITS;

    logic                          clock;
    logic                          rst;
    logic                          flush;
    logic [`LQ_WAYS-1:0]           dispatch_en;
    ld_dispatch_t [`LQ_WAYS-1:0]   dispatch;
    alu_result_t [`LQ_WAYS-1:0]    alu;
    store_entry_t [`LQ_DEPTH-1:0]  sq;
    lq_idx_t                       sq_head;
    cache_resp_t                   cache_resp;
    cache_req_t                    cache_req;
    cdb_t                          cdb;
    lq_count_t                     num_free;

    // scoreboard per ROB tag, a load is live when armed - cancelled - hits is 1
    prf_tag_t exp_prf [ROBS];
    data_t    exp_data [ROBS];
    int       armed [ROBS];
    int       cancelled [ROBS];
    int       hits [ROBS];
    bit       blocked [ROBS];

    addr_t    load_addr [ROBS];
    lq_idx_t  load_snap [ROBS];
    rob_tag_t addr_wait [$];
    rob_tag_t next_rob;

    int dispatched;
    int addressed;
    int flushed;
    int reads_expected;
    int broadcasts;
    int reads_seen;

    lq_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) clock_gen (
        .clock(clock),
        .rst  (rst)
    );

    load_queue dut0 (
        .clock      (clock),
        .rst        (rst),
        .flush      (flush),
        .dispatch_en(dispatch_en),
        .dispatch   (dispatch),
        .alu        (alu),
        .sq         (sq),
        .sq_head    (sq_head),
        .cache_resp (cache_resp),
        .cache_req  (cache_req),
        .cdb        (cdb),
        .num_free   (num_free)
    );

    task automatic fail_run(string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
            fail_run($sformatf("value mismatch on %s", name));
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // what the cache model returns for a word address
    function automatic data_t cache_word(addr_t a);
        return data_t'({a, ~a}) ^ 32'h3c5a_0f96;
    endfunction

    // youngest older store with a valid matching address, else the cache word
    function automatic data_t expected_data(addr_t a, lq_idx_t snap, output logic from_store);
        int span;
        int slot;
        data_t d;
        span = (int'(snap) - int'(sq_head) + `LQ_DEPTH) % `LQ_DEPTH;
        from_store = 1'b0;
        d = cache_word(a);
        // oldest first, so a later hit is younger
        for (int k = 0; k <= span; k++) begin
            slot = (int'(sq_head) + k) % `LQ_DEPTH;
            if (sq[slot].addr_valid && sq[slot].addr == a) begin
                from_store = 1'b1;
                d = sq[slot].data;
            end
        end
        return d;
    endfunction

    function automatic int live_loads();
        return addressed - flushed - broadcasts;
    endfunction

    task automatic wait_loads(int target, string what);
        int n;
        n = 0;
        while (live_loads() > target) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                fail_run($sformatf("timed out waiting for %s to broadcast", what));
            end
        end
    endtask

    task automatic wait_all_free();
        int n;
        n = 0;
        while (int'(num_free) != `LQ_DEPTH) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                fail_run("timed out waiting for every entry to be free");
            end
        end
    endtask

    // way w loads base + w, all ways share one store-queue snapshot
    task automatic dispatch_group(int count, addr_t base, lq_idx_t snap);
        int n;
        n = 0;
        while (int'(num_free) < count) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                fail_run("timed out waiting for free load-queue entries");
            end
        end
        for (int w = 0; w < count; w++) begin
            dispatch_en[w] = 1'b1;
            dispatch[w].rob = next_rob;
            dispatch[w].prf = prf_tag_t'($urandom);
            dispatch[w].sq_tail = snap;
            exp_prf[next_rob] = dispatch[w].prf;
            load_addr[next_rob] = base + addr_t'(w);
            load_snap[next_rob] = snap;
            addr_wait.push_back(next_rob);
            next_rob++;
            dispatched++;
        end
        next_cycle();
        dispatch_en = '0;
    endtask

    // ALU strobes for every dispatched load, expected data fixed here
    task automatic send_addresses();
        rob_tag_t r;
        logic from_store;
        while (addr_wait.size() != 0) begin
            alu = '0;
            for (int w = 0; w < `LQ_WAYS; w++) begin
                if (addr_wait.size() != 0) begin
                    r = addr_wait.pop_front();
                    alu[w].valid = 1'b1;
                    alu[w].rob = r;
                    alu[w].addr = load_addr[r];
                    exp_data[r] = expected_data(load_addr[r], load_snap[r], from_store);
                    if (!from_store) begin
                        reads_expected++;
                    end
                    armed[r]++;
                    addressed++;
                end
            end
            next_cycle();
        end
        alu = '0;
    endtask

    task automatic set_store(int slot, addr_t a, data_t d, logic dv);
        sq[slot].addr = a;
        sq[slot].data = d;
        sq[slot].addr_valid = 1'b1;
        sq[slot].data_valid = dv;
    endtask

    // compare every CDB strobe with the scoreboard
    always @(negedge clock) begin
        if (!rst && cdb.valid) begin
            if (armed[cdb.rob] - cancelled[cdb.rob] - hits[cdb.rob] != 1) begin
                fail_run($sformatf("CDB strobe for ROB tag %0d with no load in flight", cdb.rob));
            end
            if (blocked[cdb.rob]) begin
                fail_run("a load broadcast before its store data was valid");
            end
            check_value("cdb.prf", 64'(cdb.prf), 64'(exp_prf[cdb.rob]));
            check_value("cdb.data", 64'(cdb.data), 64'(exp_data[cdb.rob]));
            hits[cdb.rob]++;
            broadcasts++;
        end
    end

    // cache model, one response per cycle, 1 to 3 cycles after the request
    initial begin : cache_model
        int cycle;
        int pick;
        lq_idx_t q_idx [$];
        addr_t q_addr [$];
        int q_due [$];
        cache_resp = '0;
        cycle = 0;
        forever begin
            @(negedge clock);
            if (!rst && cache_req.valid) begin
                q_idx.push_back(cache_req.idx);
                q_addr.push_back(cache_req.addr);
                q_due.push_back(cycle + int'($urandom_range(3, 1)));
                reads_seen++;
            end
            @(posedge clock);
            cycle++;
            // a flush drops every read still in flight
            if (flush) begin
                q_idx.delete();
                q_addr.delete();
                q_due.delete();
            end
            #2;
            pick = -1;
            for (int i = q_due.size() - 1; i >= 0; i--) begin
                if (q_due[i] <= cycle) begin
                    pick = i;
                end
            end
            cache_resp = '0;
            if (pick >= 0) begin
                cache_resp.valid = 1'b1;
                cache_resp.idx = q_idx[pick];
                cache_resp.data = cache_word(q_addr[pick]);
                q_idx.delete(pick);
                q_addr.delete(pick);
                q_due.delete(pick);
            end
        end
    end

    initial begin : stimulus
        rob_tag_t held;
        addr_t base;
        int n;
        void'($urandom(SEED));
        flush = 1'b0;
        dispatch_en = '0;
        dispatch = '0;
        alu = '0;
        sq = '0;
        sq_head = '0;
        next_rob = '0;

        n = 0;
        @(negedge clock);
        while (rst !== 1'b0) begin
            @(negedge clock);
            n++;
            if (n > TIMEOUT) begin
                fail_run("reset was never released");
            end
        end
        next_cycle();

        // idle after reset
        for (int i = 0; i < 4; i++) begin
            check_value("cache_req.valid", 64'(cache_req.valid), 64'(0));
            check_value("cdb.valid", 64'(cdb.valid), 64'(0));
            check_value("num_free", 64'(num_free), 64'(`LQ_DEPTH));
            next_cycle();
        end

        // stores hold the load addresses but no valid address, all loads read the cache
        for (int g = 0; g < 6; g++) begin
            base = addr_t'($urandom);
            for (int s = 0; s < `LQ_DEPTH; s++) begin
                sq[s].addr = base + addr_t'(s % `LQ_WAYS);
                sq[s].data = ~cache_word(sq[s].addr);
                sq[s].data_valid = 1'b1;
            end
            dispatch_group(`LQ_WAYS, base, lq_idx_t'($urandom));
            send_addresses();
        end
        wait_loads(0, "cache loads");
        check_value("cache reads", 64'(reads_seen), 64'(reads_expected));

        // forwarding across the wrap, slots 1 and 2 lie past some snapshots
        sq = '0;
        sq_head = lq_idx_t'(6);
        set_store(6, 16'h0100, 32'h6666_0006, 1'b1);
        set_store(7, 16'h0100, 32'h7777_0007, 1'b1);
        set_store(0, 16'h0101, 32'h0000_a000, 1'b1);
        set_store(1, 16'h0100, 32'h1111_0001, 1'b1);
        set_store(2, 16'h0102, 32'h2222_0002, 1'b1);
        dispatch_group(`LQ_WAYS, 16'h0100, lq_idx_t'(0));
        dispatch_group(`LQ_WAYS, 16'h0100, lq_idx_t'(1));
        send_addresses();
        dispatch_group(`LQ_WAYS, 16'h0102, lq_idx_t'(0));
        dispatch_group(`LQ_WAYS, 16'h0100, lq_idx_t'(7));
        send_addresses();
        wait_loads(0, "forwarded loads");
        check_value("cache reads", 64'(reads_seen), 64'(reads_expected));

        // youngest match has no data yet
        sq = '0;
        sq_head = lq_idx_t'(2);
        set_store(2, 16'h0200, 32'h2020_0002, 1'b1);
        set_store(3, 16'h0200, 32'h3030_0003, 1'b0);
        held = next_rob;
        blocked[held] = 1'b1;
        dispatch_group(`LQ_WAYS, 16'h0200, lq_idx_t'(3));
        send_addresses();
        wait_loads(1, "the load without a store match");
        repeat (10) next_cycle();
        check_value("loads in flight", 64'(live_loads()), 64'(1));
        sq[3].data_valid = 1'b1;
        blocked[held] = 1'b0;
        wait_loads(0, "the waiting load");

        // fill the queue
        sq = '0;
        sq_head = '0;
        for (int g = 0; g < `LQ_DEPTH / `LQ_WAYS; g++) begin
            dispatch_group(`LQ_WAYS, addr_t'($urandom), lq_idx_t'($urandom));
        end
        check_value("num_free", 64'(num_free), 64'(0));
        send_addresses();
        wait_loads(0, "the full queue");
        wait_all_free();
        check_value("broadcasts", 64'(broadcasts), 64'(dispatched));

        // flush loads that wait on store data
        sq_head = lq_idx_t'(2);
        set_store(2, 16'h0301, 32'h0301_0301, 1'b0);
        set_store(3, 16'h0300, 32'h0300_0300, 1'b0);
        dispatch_group(`LQ_WAYS, 16'h0300, lq_idx_t'(3));
        dispatch_group(`LQ_WAYS, 16'h0300, lq_idx_t'(3));
        send_addresses();
        repeat (4) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        for (int r = 0; r < ROBS; r++) begin
            if (armed[r] - cancelled[r] - hits[r] == 1) begin
                cancelled[r]++;
                flushed++;
            end
        end
        sq[2].data_valid = 1'b1;
        sq[3].data_valid = 1'b1;
        repeat (10) next_cycle();
        check_value("num_free", 64'(num_free), 64'(`LQ_DEPTH));
        check_value("broadcasts", 64'(broadcasts), 64'(dispatched - flushed));
        check_value("cache reads", 64'(reads_seen), 64'(reads_expected));

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: verif/lq_clock_gen.sv
module lq_clock_gen #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

    // released 2 ns after the last reset edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 rst = 1'b0;
    end

endmodule

// File: rtl/load_queue.sv
`include "lq_config.svh"

module load_queue (
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    flush,
    input  logic [`LQ_WAYS-1:0]                     dispatch_en,
    input  lq_pkg::ld_dispatch_t [`LQ_WAYS-1:0]     dispatch,
    input  lq_pkg::alu_result_t [`LQ_WAYS-1:0]      alu,
    input  lq_pkg::store_entry_t [`LQ_DEPTH-1:0]    sq,
    input  lq_pkg::lq_idx_t                         sq_head,
    input  lq_pkg::cache_resp_t                     cache_resp,
    output lq_pkg::cache_req_t                      cache_req,
    output lq_pkg::cdb_t                            cdb,
    output lq_pkg::lq_count_t                       num_free
);
    import lq_pkg::*;

    lq_mask_t free_mask;
    lq_mask_t alloc_mask;
    lq_mask_t pending_mask;
    lq_mask_t done_mask;
    lq_mask_t read_mask;
    lq_mask_t fwd_mask;
    lq_mask_t cache_gnt;
    lq_mask_t cdb_gnt;

    ld_dispatch_t [`LQ_DEPTH-1:0] alloc_data;
    addr_t [`LQ_DEPTH-1:0]        entry_addr;
    lq_idx_t [`LQ_DEPTH-1:0]      snapshot;
    ld_tags_t [`LQ_DEPTH-1:0]     tags;
    data_t [`LQ_DEPTH-1:0]        fwd_data;

    logic     cache_valid;
    lq_idx_t  cache_idx;
    addr_t    cache_addr;
    logic     cdb_valid;
    ld_tags_t cdb_sel;

    lq_alloc alloc (
        .free_mask  (free_mask),
        .dispatch_en(dispatch_en),
        .dispatch   (dispatch),
        .alloc_mask (alloc_mask),
        .alloc_data (alloc_data)
    );

    lq_entries entries (
        .clock       (clock),
        .rst         (rst),
        .flush       (flush),
        .alloc_mask  (alloc_mask),
        .alloc_data  (alloc_data),
        .alu         (alu),
        .cache_resp  (cache_resp),
        .fwd_mask    (fwd_mask),
        .fwd_data    (fwd_data),
        .cache_gnt   (cache_gnt),
        .cdb_gnt     (cdb_gnt),
        .free_mask   (free_mask),
        .pending_mask(pending_mask),
        .done_mask   (done_mask),
        .addr        (entry_addr),
        .snapshot    (snapshot),
        .tags        (tags),
        .num_free    (num_free)
    );

    store_forward fwd (
        .clock       (clock),
        .rst         (rst),
        .flush       (flush),
        .sq          (sq),
        .sq_head     (sq_head),
        .addr        (entry_addr),
        .snapshot    (snapshot),
        .pending_mask(pending_mask),
        .read_mask   (read_mask),
        .fwd_mask    (fwd_mask),
        .fwd_data    (fwd_data)
    );

    rr_arbiter #(.payload_t(addr_t)) cache_arb (
        .clock  (clock),
        .rst    (rst),
        .req    (read_mask),
        .payload(entry_addr),
        .gnt    (cache_gnt),
        .valid  (cache_valid),
        .idx    (cache_idx),
        .sel    (cache_addr)
    );

    rr_arbiter #(.payload_t(ld_tags_t)) cdb_arb (
        .clock  (clock),
        .rst    (rst),
        .req    (done_mask),
        .payload(tags),
        .gnt    (cdb_gnt),
        .valid  (cdb_valid),
        .idx    (),
        .sel    (cdb_sel)
    );

    assign cache_req.valid = cache_valid;
    assign cache_req.idx = cache_idx;
    assign cache_req.addr = cache_addr;

    assign cdb.valid = cdb_valid;
    assign cdb.rob = cdb_sel.rob;
    assign cdb.prf = cdb_sel.prf;
    assign cdb.data = cdb_sel.data;

endmodule

// File: rtl/lq_entries.sv
`include "lq_config.svh"

module lq_entries (
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    flush,
    input  lq_pkg::lq_mask_t                        alloc_mask,
    input  lq_pkg::ld_dispatch_t [`LQ_DEPTH-1:0]    alloc_data,
    input  lq_pkg::alu_result_t [`LQ_WAYS-1:0]      alu,
    input  lq_pkg::cache_resp_t                     cache_resp,
    input  lq_pkg::lq_mask_t                        fwd_mask,
    input  lq_pkg::data_t [`LQ_DEPTH-1:0]           fwd_data,
    input  lq_pkg::lq_mask_t                        cache_gnt,
    input  lq_pkg::lq_mask_t                        cdb_gnt,
    output lq_pkg::lq_mask_t                        free_mask,
    output lq_pkg::lq_mask_t                        pending_mask,
    output lq_pkg::lq_mask_t                        done_mask,
    output lq_pkg::addr_t [`LQ_DEPTH-1:0]           addr,
    output lq_pkg::lq_idx_t [`LQ_DEPTH-1:0]         snapshot,
    output lq_pkg::ld_tags_t [`LQ_DEPTH-1:0]        tags,
    output lq_pkg::lq_count_t                       num_free
);
    import lq_pkg::*;

    lq_mask_t free;
    lq_mask_t addr_ready;
    lq_mask_t issued;
    lq_mask_t done;

    lq_mask_t               free_next;
    lq_count_t              free_cnt;
    lq_mask_t               alu_hit;
    addr_t [`LQ_DEPTH-1:0]  alu_addr;
    lq_mask_t               resp_hit;

    // address capture by ROB tag
    always_comb begin
        alu_hit = '0;
        alu_addr = '0;
        for (int e = 0; e < `LQ_DEPTH; e++) begin
            for (int w = 0; w < `LQ_WAYS; w++) begin
                if (alu[w].valid && !free[e] && !addr_ready[e] &&
                    alu[w].rob == tags[e].rob) begin
                    alu_hit[e] = 1'b1;
                    alu_addr[e] = alu[w].addr;
                end
            end
        end
    end

    always_comb begin
        for (int e = 0; e < `LQ_DEPTH; e++) begin
            resp_hit[e] = cache_resp.valid && (cache_resp.idx == lq_idx_t'(e)) && issued[e];
        end
    end

    // freed by broadcast, taken by dispatch
    always_comb begin
        free_next = (free | cdb_gnt) & ~alloc_mask;
        free_cnt = '0;
        for (int e = 0; e < `LQ_DEPTH; e++) begin
            free_cnt = free_cnt + lq_count_t'(free_next[e]);
        end
    end

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            free <= '1;
            addr_ready <= '0;
            issued <= '0;
            done <= '0;
            num_free <= lq_count_t'(`LQ_DEPTH);
        end else begin
            free <= free_next;
            addr_ready <= (addr_ready | alu_hit) & ~free_next;
            issued <= (issued | cache_gnt) & ~free_next;
            done <= (done | fwd_mask | resp_hit) & ~free_next;
            // upstream may only dispatch a full group
            num_free <= (free_cnt < `LQ_WAYS) ? '0 : free_cnt;
        end
    end

    always_ff @(posedge clock) begin
        for (int e = 0; e < `LQ_DEPTH; e++) begin
            if (alloc_mask[e]) begin
                tags[e].rob <= alloc_data[e].rob;
                tags[e].prf <= alloc_data[e].prf;
                snapshot[e] <= alloc_data[e].sq_tail;
            end
            if (alu_hit[e]) begin
                addr[e] <= alu_addr[e];
            end
            if (fwd_mask[e]) begin
                tags[e].data <= fwd_data[e];
            end else if (resp_hit[e]) begin
                tags[e].data <= cache_resp.data;
            end
        end
    end

    assign free_mask = free;
    assign pending_mask = ~free & addr_ready & ~issued & ~done;
    assign done_mask = done;

    // the cache only answers what was requested
    assert property (@(posedge clock) disable iff (rst)
        cache_resp.valid |-> issued[cache_resp.idx]);

    // count never above the entries actually free
    assert property (@(posedge clock) disable iff (rst)
        num_free <= $countones(free));

endmodule

// File: rtl/store_forward.sv
`include "lq_config.svh"

module store_forward (
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    flush,
    input  lq_pkg::store_entry_t [`LQ_DEPTH-1:0]    sq,
    input  lq_pkg::lq_idx_t                         sq_head,
    input  lq_pkg::addr_t [`LQ_DEPTH-1:0]           addr,
    input  lq_pkg::lq_idx_t [`LQ_DEPTH-1:0]         snapshot,
    input  lq_pkg::lq_mask_t                        pending_mask,
    output lq_pkg::lq_mask_t                        read_mask,
    output lq_pkg::lq_mask_t                        fwd_mask,
    output lq_pkg::data_t [`LQ_DEPTH-1:0]           fwd_data
);
    import lq_pkg::*;

    // [load][store]
    lq_mask_t [`LQ_DEPTH-1:0] older;
    lq_mask_t [`LQ_DEPTH-1:0] hit;

    lq_idx_t [`LQ_DEPTH-1:0]  youngest;
    lq_mask_t                 found;
    lq_mask_t                 read_d;
    lq_mask_t                 fwd_d;
    lq_mask_t                 read_q;
    lq_mask_t                 fwd_q;

    // older stores run from head to snapshot, both included
    always_comb begin
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            for (int j = 0; j < `LQ_DEPTH; j++) begin
                if (sq_head > snapshot[i]) begin
                    older[i][j] = (lq_idx_t'(j) <= snapshot[i]) || (lq_idx_t'(j) >= sq_head);
                end else begin
                    older[i][j] = (lq_idx_t'(j) >= sq_head) && (lq_idx_t'(j) <= snapshot[i]);
                end
                hit[i][j] = older[i][j] && sq[j].addr_valid && (sq[j].addr == addr[i]);
            end
        end
    end

    // walk from head in age order, the last hit is the youngest
    always_comb begin : scan
        lq_idx_t slot;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            found[i] = 1'b0;
            youngest[i] = sq_head;
            for (int k = 0; k < `LQ_DEPTH; k++) begin
                slot = sq_head + lq_idx_t'(k);
                if (hit[i][slot]) begin
                    found[i] = 1'b1;
                    youngest[i] = slot;
                end
            end
        end
    end

    // match without data means wait, neither bit set
    always_comb begin
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            read_d[i] = pending_mask[i] && !found[i];
            fwd_d[i] = pending_mask[i] && found[i] && sq[youngest[i]].data_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            read_q <= '0;
            fwd_q <= '0;
        end else begin
            read_q <= read_d;
            fwd_q <= fwd_d;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            fwd_data[i] <= sq[youngest[i]].data;
        end
    end

    // drop decisions for entries already issued or done since
    assign read_mask = read_q & pending_mask;
    assign fwd_mask = fwd_q & pending_mask;

endmodule

// File: rtl/lq_alloc.sv
`include "lq_config.svh"

module lq_alloc (
    input  lq_pkg::lq_mask_t                        free_mask,
    input  logic [`LQ_WAYS-1:0]                     dispatch_en,
    input  lq_pkg::ld_dispatch_t [`LQ_WAYS-1:0]     dispatch,
    output lq_pkg::lq_mask_t                        alloc_mask,
    output lq_pkg::ld_dispatch_t [`LQ_DEPTH-1:0]    alloc_data
);
    import lq_pkg::*;

    lq_mask_t [`LQ_WAYS-1:0] way_gnt;
    lq_mask_t                overlap;

    // isolate lowest set bit
    function automatic lq_mask_t lowest(lq_mask_t m);
        return m & (~m + lq_mask_t'(1));
    endfunction

    // same on the bit-reversed vector
    function automatic lq_mask_t highest(lq_mask_t m);
        lq_mask_t r;
        r = {<<{m}};
        r = r & (~r + lq_mask_t'(1));
        return {<<{r}};
    endfunction

    // even ways from the bottom, odd ways from the top
    always_comb begin : pick
        lq_mask_t remaining;
        remaining = free_mask;
        for (int w = 0; w < `LQ_WAYS; w++) begin
            if (!dispatch_en[w]) begin
                way_gnt[w] = '0;
            end else if (w % 2 == 0) begin
                way_gnt[w] = lowest(remaining);
            end else begin
                way_gnt[w] = highest(remaining);
            end
            remaining = remaining & ~way_gnt[w];
        end
    end

    always_comb begin
        alloc_mask = '0;
        overlap = '0;
        alloc_data = '0;
        for (int w = 0; w < `LQ_WAYS; w++) begin
            overlap = overlap | (alloc_mask & way_gnt[w]);
            alloc_mask = alloc_mask | way_gnt[w];
            for (int e = 0; e < `LQ_DEPTH; e++) begin
                if (way_gnt[w][e]) begin
                    alloc_data[e] = dispatch[w];
                end
            end
        end
        assert (overlap == '0);
    end

endmodule

// File: rtl/rr_arbiter.sv
`include "lq_config.svh"

module rr_arbiter #(
    parameter type payload_t = logic [`LQ_DATA_BITS-1:0]
) (
    input  logic                        clock,
    input  logic                        rst,
    input  lq_pkg::lq_mask_t            req,
    input  payload_t [`LQ_DEPTH-1:0]    payload,
    output lq_pkg::lq_mask_t            gnt,
    output logic                        valid,
    output lq_pkg::lq_idx_t             idx,
    output payload_t                    sel
);
    import lq_pkg::*;

    // last granted entry, search starts just after it
    lq_idx_t last;

    always_comb begin : search
        lq_idx_t slot;
        valid = 1'b0;
        idx = '0;
        // k = depth wraps back onto last itself, so it comes last
        for (int k = 1; k <= `LQ_DEPTH; k++) begin
            slot = last + lq_idx_t'(k);
            if (!valid && req[slot]) begin
                valid = 1'b1;
                idx = slot;
            end
        end
    end

    assign gnt = valid ? (lq_mask_t'(1) << idx) : '0;
    assign sel = valid ? payload[idx] : '0;

    always_ff @(posedge clock) begin
        if (rst) begin
            last <= lq_idx_t'(`LQ_DEPTH - 1);
        end else if (valid) begin
            last <= idx;
        end
    end

    // one grant to a requester, the last winner only when it asks alone
    assert property (@(posedge clock) disable iff (rst)
        $onehot0(gnt) && ((gnt & ~req) == '0) && (!gnt[last] || req == gnt));

endmodule

// File: rtl/lq_pkg.sv
`include "lq_config.svh"

package lq_pkg;

    // entry or store-queue slot index
    typedef logic [$clog2(`LQ_DEPTH)-1:0] lq_idx_t;
    typedef logic [$clog2(`LQ_DEPTH):0]   lq_count_t;
    typedef logic [`LQ_DEPTH-1:0]         lq_mask_t;

    typedef logic [`LQ_ROB_BITS-1:0]  rob_tag_t;
    typedef logic [`LQ_PRF_BITS-1:0]  prf_tag_t;
    typedef logic [`LQ_ADDR_BITS-1:0] addr_t;
    typedef logic [`LQ_DATA_BITS-1:0] data_t;

    // one new load, sq_tail is the youngest older store slot
    typedef struct packed {
        rob_tag_t rob;
        prf_tag_t prf;
        lq_idx_t  sq_tail;
    } ld_dispatch_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t rob;
        addr_t    addr;
    } alu_result_t;

    typedef struct packed {
        addr_t addr;
        data_t data;
        logic  addr_valid;
        logic  data_valid;
    } store_entry_t;

    typedef struct packed {
        logic    valid;
        lq_idx_t idx;
        addr_t   addr;
    } cache_req_t;

    typedef struct packed {
        logic    valid;
        lq_idx_t idx;
        data_t   data;
    } cache_resp_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t rob;
        prf_tag_t prf;
        data_t    data;
    } cdb_t;

    // what an entry puts on the CDB
    typedef struct packed {
        rob_tag_t rob;
        prf_tag_t prf;
        data_t    data;
    } ld_tags_t;

endpackage

// File: rtl/lq_config.svh
`ifndef LQ_CONFIG_SVH
`define LQ_CONFIG_SVH

// load-queue entries, also the store-queue depth
`define LQ_DEPTH 8

// dispatch and ALU width
`define LQ_WAYS 2

// ROB tag width
`define LQ_ROB_BITS 5

// physical register tag width
`define LQ_PRF_BITS 6

// word address width
`define LQ_ADDR_BITS 16

// load and store data width
`define LQ_DATA_BITS 32

`endif
